//--- gps_pkg.sv
package gps_pkg;

   localparam int input_width = 3;
   localparam int code_len = 1023;
   localparam int chip_width = 10;
   localparam int phase_width = 16;
   localparam int dopp_width = 16;
   localparam int acc_width = 16;
   localparam int power_width = 32;

   typedef logic signed [input_width-1:0] sample_t;
   typedef logic [chip_width-1:0] chip_idx_t;
   typedef logic [phase_width-1:0] phase_t;
   typedef logic signed [dopp_width-1:0] doppler_t;
   typedef logic signed [acc_width-1:0] acc_t;
   typedef logic [power_width-1:0] power_t;
   typedef logic [4:0] prn_t;
   typedef logic signed [2:0] carrier_t;

   // Offset between adjacent Doppler bins.
   localparam doppler_t dopp_bin_inc = 16'sd64;

   // Carrier replica, indexed by the top three phase bits.
   localparam carrier_t carrier_cos [8] = '{
      3'sd2, 3'sd1, -3'sd1, -3'sd2, -3'sd2, -3'sd1, 3'sd1, 3'sd2
   };
   localparam carrier_t carrier_sin [8] = '{
      3'sd1, 3'sd2, 3'sd2, 3'sd1, -3'sd1, -3'sd2, -3'sd2, -3'sd1
   };

   // G2 phase selector taps {tap_a, tap_b}, stages numbered 1 to 10.
   localparam logic [7:0] g2_taps [32] = '{
      8'h26, 8'h37, 8'h48, 8'h59, 8'h19, 8'h2a, 8'h18, 8'h29,
      8'h3a, 8'h23, 8'h34, 8'h56, 8'h67, 8'h78, 8'h89, 8'h9a,
      8'h14, 8'h25, 8'h36, 8'h47, 8'h58, 8'h69, 8'h13, 8'h46,
      8'h57, 8'h68, 8'h79, 8'h8a, 8'h16, 8'h27, 8'h38, 8'h49
   };

   // Integrated I and Q of one Doppler bin.
   typedef struct packed {
      acc_t i;
      acc_t q;
   } corr_result_t;

endpackage

//--- sample_sync.sv
module sample_sync #(
   parameter int width = 1
) (
   input  logic             clk,
   input  logic [width-1:0] async_in,
   output logic [width-1:0] sync_out
);

   logic [width-1:0] meta;

   // Two stages, fixed delay of two clocks.
   always_ff @(posedge clk) begin
      meta <= async_in;
      sync_out <= meta;
   end

endmodule

//--- ca_code_gen.sv
module ca_code_gen
   import gps_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  logic      restart,
   input  logic      advance,
   input  prn_t      prn,
   output logic      chip,
   output chip_idx_t chip_idx,
   output logic      epoch
);

   logic [9:0] g1;
   logic [9:0] g2;
   logic [7:0] taps;
   logic [3:0] tap_a;
   logic [3:0] tap_b;
   logic       g1_fb;
   logic       g2_fb;

   // Bit 0 holds stage 1, bit 9 holds stage 10.
   assign taps = g2_taps[prn];
   assign tap_a = taps[7:4];
   assign tap_b = taps[3:0];

   assign g1_fb = g1[2] ^ g1[9];
   assign g2_fb = g2[1] ^ g2[2] ^ g2[5] ^ g2[7] ^ g2[8] ^ g2[9];

   assign chip = g1[9] ^ g2[tap_a - 4'd1] ^ g2[tap_b - 4'd1];

   // Last chip of the period being consumed.
   assign epoch = advance && (chip_idx == chip_idx_t'(code_len - 1));

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         g1 <= '1;
         g2 <= '1;
         chip_idx <= '0;
      end else if (restart || epoch) begin
         // Back to chip 0.
         g1 <= '1;
         g2 <= '1;
         chip_idx <= '0;
      end else if (advance) begin
         g1 <= {g1[8:0], g1_fb};
         g2 <= {g2[8:0], g2_fb};
         chip_idx <= chip_idx + 1'b1;
      end
   end

endmodule

//--- carrier_nco.sv
module carrier_nco
   import gps_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  logic     restart,
   input  logic     step,
   input  doppler_t increment,
   output carrier_t cos_val,
   output carrier_t sin_val
);

   phase_t     phase;
   logic [2:0] idx;

   // Replica of the current phase, before the step.
   assign idx = phase[phase_width-1 -: 3];
   assign cos_val = carrier_cos[idx];
   assign sin_val = carrier_sin[idx];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         phase <= '0;
      end else if (restart) begin
         phase <= '0;
      end else if (step) begin
         // Negative Doppler wraps backwards.
         phase <= phase + phase_t'(increment);
      end
   end

endmodule

//--- correlator.sv
module correlator
   import gps_pkg::*;
(
   input  logic         clk,
   input  logic         rst_n,
   input  logic         restart,
   input  logic         sample_valid,
   input  sample_t      wiped,
   input  carrier_t     cos_val,
   input  carrier_t     sin_val,
   input  logic         dump,
   output corr_result_t result
);

   acc_t              acc_i;
   acc_t              acc_q;
   logic signed [5:0] prod_i;
   logic signed [5:0] prod_q;
   acc_t              sum_i;
   acc_t              sum_q;

   assign prod_i = wiped * cos_val;
   assign prod_q = wiped * sin_val;

   // Running totals including this sample.
   assign sum_i = acc_i + prod_i;
   assign sum_q = acc_q + prod_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         acc_i <= '0;
         acc_q <= '0;
      end else if (restart) begin
         acc_i <= '0;
         acc_q <= '0;
      end else if (sample_valid) begin
         if (dump) begin
            acc_i <= '0;
            acc_q <= '0;
         end else begin
            acc_i <= sum_i;
            acc_q <= sum_q;
         end
      end
   end

   // Epoch sample is part of the dumped period.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         result <= '0;
      end else if (sample_valid && dump) begin
         result.i <= sum_i;
         result.q <= sum_q;
      end
   end

endmodule

//--- power_calc.sv
module power_calc
   import gps_pkg::*;
(
   input  logic         clk,
   input  logic         rst_n,
   input  logic         dump_done,
   input  corr_result_t early,
   input  corr_result_t prompt,
   input  corr_result_t late,
   output logic         i2q2_valid,
   output power_t       i2q2_early,
   output power_t       i2q2_prompt,
   output power_t       i2q2_late
);

   function automatic power_t power_of(corr_result_t r);
      logic signed [31:0] sq_i;
      logic signed [31:0] sq_q;
      sq_i = r.i * r.i;
      sq_q = r.q * r.q;
      // Sum may reach 2^31, so add unsigned.
      return power_t'(sq_i) + power_t'(sq_q);
   endfunction

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         i2q2_valid <= 1'b0;
         i2q2_early <= '0;
         i2q2_prompt <= '0;
         i2q2_late <= '0;
      end else begin
         i2q2_valid <= dump_done;
         if (dump_done) begin
            i2q2_early <= power_of(early);
            i2q2_prompt <= power_of(prompt);
            i2q2_late <= power_of(late);
         end
      end
   end

endmodule

//--- tracking_channel.sv
module tracking_channel
   import gps_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  logic      feed_restart,
   input  logic      sample_valid,
   input  sample_t   sample,
   input  doppler_t  doppler,
   input  prn_t      prn,
   input  logic      seek_en,
   input  chip_idx_t seek_target,
   output chip_idx_t code_shift,
   output acc_t      accumulator_i,
   output acc_t      accumulator_q,
   output logic      i2q2_valid,
   output power_t    i2q2_early,
   output power_t    i2q2_prompt,
   output power_t    i2q2_late,
   output logic      ca_bit,
   output chip_idx_t ca_code_shift
);

   logic         chip;
   logic         epoch;
   logic         hold;
   logic         advance;
   logic         dump_done;
   sample_t      wiped;
   doppler_t     dopp_inc [3];
   corr_result_t results [3];

   // Slip one chip per sample until the target shift is reached.
   assign hold = seek_en && (code_shift != seek_target);
   assign advance = sample_valid && !hold;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         code_shift <= '0;
      end else if (feed_restart) begin
         code_shift <= '0;
      end else if (sample_valid && hold) begin
         if (code_shift == chip_idx_t'(code_len - 1)) begin
            code_shift <= '0;
         end else begin
            code_shift <= code_shift + 1'b1;
         end
      end
   end

   ca_code_gen code_gen_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .restart  (feed_restart),
      .advance  (advance),
      .prn      (prn),
      .chip     (chip),
      .chip_idx (ca_code_shift),
      .epoch    (epoch)
   );

   assign ca_bit = chip;

   // Chip 1 maps to -1.
   assign wiped = chip ? sample_t'(-sample) : sample;

   // Bins: 0 early, 1 prompt, 2 late.
   assign dopp_inc[0] = doppler + dopp_bin_inc;
   assign dopp_inc[1] = doppler;
   assign dopp_inc[2] = doppler - dopp_bin_inc;

   for (genvar b = 0; b < 3; b++) begin : g_bin
      carrier_t cos_val;
      carrier_t sin_val;

      carrier_nco nco_i (
         .clk       (clk),
         .rst_n     (rst_n),
         .restart   (feed_restart),
         .step      (sample_valid),
         .increment (dopp_inc[b]),
         .cos_val   (cos_val),
         .sin_val   (sin_val)
      );

      correlator corr_i (
         .clk          (clk),
         .rst_n        (rst_n),
         .restart      (feed_restart),
         .sample_valid (sample_valid),
         .wiped        (wiped),
         .cos_val      (cos_val),
         .sin_val      (sin_val),
         .dump         (epoch),
         .result       (results[b])
      );
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         dump_done <= 1'b0;
      end else begin
         dump_done <= epoch;
      end
   end

   assign accumulator_i = results[1].i;
   assign accumulator_q = results[1].q;

   power_calc power_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .dump_done   (dump_done),
      .early       (results[0]),
      .prompt      (results[1]),
      .late        (results[2]),
      .i2q2_valid  (i2q2_valid),
      .i2q2_early  (i2q2_early),
      .i2q2_prompt (i2q2_prompt),
      .i2q2_late   (i2q2_late)
   );

endmodule

//--- gps_top.sv
module gps_top
   import gps_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  logic      feed_reset,
   input  logic      feed_complete,
   input  sample_t   data,
   input  doppler_t  doppler,
   input  prn_t      prn,
   input  logic      seek_en,
   input  chip_idx_t seek_target,
   output chip_idx_t code_shift,
   output acc_t      accumulator_i,
   output acc_t      accumulator_q,
   output logic      i2q2_valid,
   output power_t    i2q2_early,
   output power_t    i2q2_prompt,
   output power_t    i2q2_late,
   output logic      ca_bit,
   output chip_idx_t ca_code_shift
);

   logic    feed_reset_sync;
   logic    feed_complete_sync;
   sample_t data_sync;
   logic    done;
   logic    sample_valid;

   // Equal depth keeps controls aligned with the data.
   sample_sync feed_reset_sync_i (
      .clk      (clk),
      .async_in (feed_reset),
      .sync_out (feed_reset_sync)
   );

   sample_sync feed_complete_sync_i (
      .clk      (clk),
      .async_in (feed_complete),
      .sync_out (feed_complete_sync)
   );

   sample_sync #(.width(input_width)) data_sync_i (
      .clk      (clk),
      .async_in (data),
      .sync_out (data_sync)
   );

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         done <= 1'b0;
      end else if (feed_reset_sync) begin
         done <= 1'b0;
      end else if (feed_complete_sync) begin
         done <= 1'b1;
      end
   end

   // One sample per clock while the feed runs.
   assign sample_valid = rst_n && !feed_reset_sync && !feed_complete_sync && !done;

   tracking_channel channel_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .feed_restart  (feed_reset_sync),
      .sample_valid  (sample_valid),
      .sample        (data_sync),
      .doppler       (doppler),
      .prn           (prn),
      .seek_en       (seek_en),
      .seek_target   (seek_target),
      .code_shift    (code_shift),
      .accumulator_i (accumulator_i),
      .accumulator_q (accumulator_q),
      .i2q2_valid    (i2q2_valid),
      .i2q2_early    (i2q2_early),
      .i2q2_prompt   (i2q2_prompt),
      .i2q2_late     (i2q2_late),
      .ca_bit        (ca_bit),
      .ca_code_shift (ca_code_shift)
   );

endmodule

//--- gps_top_checker.sv
module gps_top_checker
   import gps_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic       feed_reset,
   input  logic       feed_complete,
   input  sample_t    data,
   input  doppler_t   doppler,
   input  prn_t       prn,
   input  logic       seek_en,
   input  chip_idx_t  seek_target,
   input  chip_idx_t  code_shift,
   input  acc_t       accumulator_i,
   input  acc_t       accumulator_q,
   input  logic       i2q2_valid,
   input  power_t     i2q2_early,
   input  power_t     i2q2_prompt,
   input  power_t     i2q2_late,
   input  logic       ca_bit,
   input  chip_idx_t  ca_code_shift,
   input  logic       first_en,
   input  logic [9:0] exp_first,
   input  logic       chk_prompt,
   input  acc_t       exp_i,
   input  acc_t       exp_q,
   output int         errors,
   output int         checks,
   output int         dumps
);

   typedef struct packed {
      logic      valid;
      logic      chip;
      chip_idx_t idx;
      chip_idx_t shift;
   } chip_rec_t;

   typedef struct packed {
      logic   valid;
      int     i;
      int     q;
      power_t early;
      power_t prompt;
      power_t late;
   } dump_rec_t;

   logic [10:1] g1;
   logic [10:1] g2;
   chip_idx_t   idx;
   chip_idx_t   shift;
   phase_t      phase [3];
   int          sum_i [3];
   int          sum_q [3];
   logic        done;
   int          nfirst;
   logic [9:0]  first;
   chip_rec_t   chip_pipe [2];
   dump_rec_t   dump_pipe [4];

   task automatic compare(input string name, input logic signed [63:0] actual,
                          input logic signed [63:0] expected);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("[FAIL] %0t: %s expected %0d, got %0d", $time, name, expected, actual);
      end
   endtask

   function automatic power_t bin_power(input int i, input int q);
      int ai;
      int aq;
      ai = acc_t'(i);
      aq = acc_t'(q);
      return power_t'(ai * ai + aq * aq);
   endfunction

   task automatic restart_model();
      g1 = '1;
      g2 = '1;
      idx = '0;
      shift = '0;
      done = 1'b0;
      nfirst = 0;
      for (int b = 0; b < 3; b++) begin
         phase[b] = '0;
         sum_i[b] = 0;
         sum_q[b] = 0;
      end
   endtask

   always @(posedge clk) begin
      chip_rec_t  c;
      dump_rec_t  d;
      int         w;
      logic       hold;
      logic [7:0] t;
      if (!rst_n) begin
         restart_model();
         errors = 0;
         checks = 0;
         dumps = 0;
         chip_pipe[0] = '0;
         chip_pipe[1] = '0;
         for (int k = 0; k < 4; k++) begin
            dump_pipe[k] = '0;
         end
      end else begin
         // DUT shows the chip two cycles and the dump four cycles after input.
         c = chip_pipe[1];
         d = dump_pipe[3];
         if (c.valid) begin
            compare("ca_bit", ca_bit, c.chip);
            compare("ca_code_shift", ca_code_shift, c.idx);
            compare("code_shift", code_shift, c.shift);
            if (nfirst < 10) begin
               first = {first[8:0], ca_bit};
               nfirst++;
               if (nfirst == 10 && first_en) begin
                  compare("first ten chips", first, exp_first);
               end
            end
         end
         compare("i2q2_valid", i2q2_valid, d.valid);
         if (i2q2_valid === 1'b1) begin
            dumps++;
         end
         if (d.valid) begin
            compare("accumulator_i", accumulator_i, d.i);
            compare("accumulator_q", accumulator_q, d.q);
            compare("i2q2_early", i2q2_early, d.early);
            compare("i2q2_prompt", i2q2_prompt, d.prompt);
            compare("i2q2_late", i2q2_late, d.late);
            if (chk_prompt) begin
               compare("accumulator_i", accumulator_i, exp_i);
               compare("accumulator_q", accumulator_q, exp_q);
            end
            if (doppler == 0 && (i2q2_prompt < i2q2_early || i2q2_prompt < i2q2_late)) begin
               errors++;
               $display("At time %0t the prompt power is below the early or late power",
                        $time);
            end
         end
         c = '0;
         d = '0;
         if (feed_reset) begin
            restart_model();
         end else if (feed_complete) begin
            done = 1'b1;
         end else if (!done) begin
            t = g2_taps[prn];
            hold = seek_en && (shift != seek_target);
            c.valid = 1'b1;
            c.chip = g1[10] ^ g2[t[7:4]] ^ g2[t[3:0]];
            c.idx = idx;
            c.shift = shift;
            w = c.chip ? -int'(data) : int'(data);
            for (int b = 0; b < 3; b++) begin
               sum_i[b] += w * carrier_cos[phase[b][phase_width-1 -: 3]];
               sum_q[b] += w * carrier_sin[phase[b][phase_width-1 -: 3]];
               // Bin 0 sits one bin above the prompt Doppler.
               phase[b] += phase_t'(doppler + dopp_bin_inc * (1 - b));
            end
            if (hold) begin
               shift = (shift == code_len - 1) ? '0 : shift + 1'b1;
            end else if (idx == code_len - 1) begin
               d.valid = 1'b1;
               d.i = acc_t'(sum_i[1]);
               d.q = acc_t'(sum_q[1]);
               d.early = bin_power(sum_i[0], sum_q[0]);
               d.prompt = bin_power(sum_i[1], sum_q[1]);
               d.late = bin_power(sum_i[2], sum_q[2]);
               for (int b = 0; b < 3; b++) begin
                  sum_i[b] = 0;
                  sum_q[b] = 0;
               end
               g1 = '1;
               g2 = '1;
               idx = '0;
            end else begin
               g1 = {g1[9:1], g1[3] ^ g1[10]};
               g2 = {g2[9:1], g2[2] ^ g2[3] ^ g2[6] ^ g2[8] ^ g2[9] ^ g2[10]};
               idx = idx + 1'b1;
            end
         end
         chip_pipe[1] = chip_pipe[0];
         chip_pipe[0] = c;
         for (int k = 3; k > 0; k--) begin
            dump_pipe[k] = dump_pipe[k-1];
         end
         dump_pipe[0] = d;
      end
   end

endmodule

//--- gps_top_tb.sv
module gps_top_tb;
   import gps_pkg::*;

   localparam logic [1:0] src_zero = 2'd0;
   localparam logic [1:0] src_code = 2'd1;
   localparam logic [1:0] src_noise = 2'd2;
   localparam int num_rows = 6;

   typedef struct packed {
      prn_t       prn;
      doppler_t   doppler;
      logic [1:0] src;
      logic [1:0] amp;
      logic       seek_en;
      chip_idx_t  seek_target;
      logic [2:0] periods;
      logic       first_en;
      logic [9:0] first;
      logic       chk_prompt;
      acc_t       exp_i;
      acc_t       exp_q;
   } row_t;

   // Stimulus, then expected first chips and prompt sums.
   localparam row_t rows [num_rows] = '{
      '{5'd0, 16'sd0, src_code, 2'd1, 1'b0, 10'd0, 3'd1,
        1'b1, 10'o1440, 1'b1, 16'sd2046, 16'sd1023},
      '{5'd1, 16'sd0, src_zero, 2'd0, 1'b0, 10'd0, 3'd1,
        1'b1, 10'o1620, 1'b1, 16'sd0, 16'sd0},
      '{5'd2, 16'sd0, src_code, 2'd3, 1'b0, 10'd0, 3'd2,
        1'b1, 10'o1710, 1'b1, 16'sd6138, 16'sd3069},
      '{5'd3, 16'sd0, src_code, 2'd2, 1'b0, 10'd0, 3'd1,
        1'b1, 10'o1744, 1'b1, 16'sd4092, 16'sd2046},
      '{5'd10, -16'sd150, src_noise, 2'd0, 1'b1, 10'd5, 3'd3,
        1'b0, 10'o0, 1'b0, 16'sd0, 16'sd0},
      '{5'd6, 16'sd300, src_noise, 2'd0, 1'b0, 10'd0, 3'd2,
        1'b0, 10'o0, 1'b0, 16'sd0, 16'sd0}
   };

   logic       clk;
   logic       rst_n;
   logic       feed_reset;
   logic       feed_complete;
   sample_t    data;
   doppler_t   doppler;
   prn_t       prn;
   logic       seek_en;
   chip_idx_t  seek_target;
   chip_idx_t  code_shift;
   acc_t       accumulator_i;
   acc_t       accumulator_q;
   logic       i2q2_valid;
   power_t     i2q2_early;
   power_t     i2q2_prompt;
   power_t     i2q2_late;
   logic       ca_bit;
   chip_idx_t  ca_code_shift;
   logic       first_en;
   logic [9:0] exp_first;
   logic       chk_prompt;
   acc_t       exp_i;
   acc_t       exp_q;
   int         errors;
   int         checks;
   int         dumps;
   logic       code_bits [code_len];
   logic [31:0] seed;
   int         cycles = 0;
   int         limit;
   int         exp_dumps;

   gps_top gps_top_i (.*);

   gps_top_checker checker_i (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles > limit) begin
         $display("Timeout: the run went past the limit of %0d cycles", limit);
         $display("Test failures found");
         $finish;
      end
   end

   function automatic logic [31:0] next_rand(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // One full C/A period, stages numbered 1 to 10.
   task automatic fill_code(input prn_t p);
      logic [10:1] g1;
      logic [10:1] g2;
      logic [7:0]  t;
      g1 = '1;
      g2 = '1;
      t = g2_taps[p];
      for (int n = 0; n < code_len; n++) begin
         code_bits[n] = g1[10] ^ g2[t[7:4]] ^ g2[t[3:0]];
         g1 = {g1[9:1], g1[3] ^ g1[10]};
         g2 = {g2[9:1], g2[2] ^ g2[3] ^ g2[6] ^ g2[8] ^ g2[9] ^ g2[10]};
      end
   endtask

   task automatic run_row(input row_t r);
      prn = r.prn;
      doppler = r.doppler;
      seek_en = r.seek_en;
      seek_target = r.seek_target;
      first_en = r.first_en;
      exp_first = r.first;
      chk_prompt = r.chk_prompt;
      exp_i = r.exp_i;
      exp_q = r.exp_q;
      feed_reset = 1'b1;
      fill_code(r.prn);
      repeat (4) @(negedge clk);
      feed_reset = 1'b0;
      for (int n = 0; n < r.periods * code_len; n++) begin
         case (r.src)
            src_code: data = code_bits[n % code_len] ? -sample_t'(r.amp) : sample_t'(r.amp);
            src_noise: begin
               seed = next_rand(seed);
               data = sample_t'(int'(seed[23:16] % 7) - 3);
            end
            default: data = '0;
         endcase
         @(negedge clk);
      end
      data = '0;
      feed_complete = 1'b1;
      @(negedge clk);
      feed_complete = 1'b0;
      repeat (20) @(negedge clk);
   endtask

   initial begin
      int fails;
      rst_n = 1'b0;
      feed_reset = 1'b1;
      feed_complete = 1'b0;
      data = '0;
      doppler = '0;
      prn = '0;
      seek_en = 1'b0;
      seek_target = '0;
      first_en = 1'b0;
      exp_first = '0;
      chk_prompt = 1'b0;
      exp_i = '0;
      exp_q = '0;
      seed = 32'he5db_31ac;
      limit = 100;
      exp_dumps = 0;
      foreach (rows[r]) begin
         limit += rows[r].periods * code_len + 40;
         exp_dumps += (rows[r].periods * code_len -
                       (rows[r].seek_en ? int'(rows[r].seek_target) : 0)) / code_len;
      end
      repeat (8) @(negedge clk);
      rst_n = 1'b1;
      foreach (rows[r]) begin
         run_row(rows[r]);
      end
      repeat (10) @(negedge clk);
      if (dumps != exp_dumps) begin
         $display("Wrong number of dumps: saw %0d, expected %0d", dumps, exp_dumps);
      end
      fails = errors + ((dumps != exp_dumps) ? 1 : 0);
      $display("Checks: %0d, errors: %0d", checks, fails);
      if (fails == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

//--- gps_top.f
gps_pkg.sv
sample_sync.sv
ca_code_gen.sv
carrier_nco.sv
correlator.sv
power_calc.sv
tracking_channel.sv
gps_top.sv
gps_top_checker.sv
gps_top_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := gps_top_tb
RTL_TOP    := gps_top
FILELIST   := gps_top.f
FLAGS      := --binary --timing -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing -Wall
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
